// ==== hdl/piso_pkg.sv ====
// widths, word count, vector typedefs and buffer state enum for the serializer
package piso_pkg;

    // width of one serial word on the output channel
    localparam int WORD_W = 8;

    // words per parallel bundle
    localparam int ELS = 4;

    // the non-last words taken together
    localparam int REST_W = (ELS - 1) * WORD_W;

    // counter wide enough to index every word of a bundle
    localparam int CTR_W = $clog2(ELS);

    // one serial word
    typedef logic [WORD_W-1:0] word_t;

    // one parallel bundle, word 0 in the low bits
    typedef logic [ELS*WORD_W-1:0] bundle_t;

    // words 0 to ELS-2 of a bundle
    typedef logic [REST_W-1:0] rest_t;

    // index of the word currently on the output
    typedef logic [CTR_W-1:0] ctr_t;

    // fill level of the two-entry buffer
    typedef enum logic [1:0] {
        empty = 2'd0,
        one   = 2'd1,
        two   = 2'd2
    } two_fifo_state_e;

endpackage

// ==== hdl/piso_one_fifo.sv ====
// one-entry buffer for the non-last words of a bundle
`timescale 1ns/1ns

module piso_one_fifo
(
    input  logic            clk_i,
    input  logic            rst_i,
    // write side
    input  logic            v_i,
    input  piso_pkg::rest_t data_i,
    output logic            ready_o,
    // read side, valid then yumi
    output logic            v_o,
    output piso_pkg::rest_t data_o,
    input  logic            yumi_i
);

    // occupancy flag
    logic full_r;
    // stored payload
    piso_pkg::rest_t data_r;
    // write accepted this cycle
    logic wr_en;

    // only an empty buffer takes a new entry
    assign ready_o = ~full_r;
    assign wr_en   = v_i & ~full_r;

    // flag sets on a write and clears when the entry is taken
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            full_r <= 1'b0;
        end
        else if (wr_en)
        begin
            full_r <= 1'b1;
        end
        else if (yumi_i)
        begin
            full_r <= 1'b0;
        end
    end

    // payload needs no reset, it is qualified by full_r
    always_ff @(posedge clk_i)
    begin
        if (wr_en)
        begin
            data_r <= data_i;
        end
    end

    assign v_o    = full_r;
    assign data_o = data_r;

endmodule

// ==== hdl/piso_two_fifo.sv ====
// two-entry buffer with fill state machine for the last word of each bundle
`timescale 1ns/1ns

module piso_two_fifo
(
    input  logic            clk_i,
    input  logic            rst_i,
    // write side
    input  logic            v_i,
    input  piso_pkg::word_t data_i,
    output logic            ready_o,
    // read side, valid then yumi
    output logic            v_o,
    output piso_pkg::word_t data_o,
    input  logic            yumi_i
);

    // fill state
    piso_pkg::two_fifo_state_e state_r;
    piso_pkg::two_fifo_state_e state_nxt;

    // storage slots, indexed by one-bit pointers
    piso_pkg::word_t mem_r [2];
    logic            wr_ptr_r;
    logic            rd_ptr_r;

    // handshake qualified strobes
    logic wr_en;
    logic rd_en;

    // room for another entry unless both slots hold data
    assign ready_o = (state_r != piso_pkg::two);
    assign v_o     = (state_r != piso_pkg::empty);

    assign wr_en = v_i & ready_o;
    // consumer only raises yumi while v_o is high
    assign rd_en = yumi_i;

    // next fill state
    always_comb
    begin
        state_nxt = state_r;
        case (state_r)
            piso_pkg::empty:
            begin
                if (wr_en)
                begin
                    state_nxt = piso_pkg::one;
                end
            end
            piso_pkg::one:
            begin
                // read with write keeps one entry
                if (wr_en & ~rd_en)
                begin
                    state_nxt = piso_pkg::two;
                end
                else if (rd_en & ~wr_en)
                begin
                    state_nxt = piso_pkg::empty;
                end
            end
            piso_pkg::two:
            begin
                // full, so only a read moves the state
                if (rd_en)
                begin
                    state_nxt = piso_pkg::one;
                end
            end
            default:
            begin
                state_nxt = piso_pkg::empty;
            end
        endcase
    end

    // state and pointers
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_r  <= piso_pkg::empty;
            wr_ptr_r <= 1'b0;
            rd_ptr_r <= 1'b0;
        end
        else
        begin
            state_r <= state_nxt;
            if (wr_en)
            begin
                wr_ptr_r <= ~wr_ptr_r;
            end
            if (rd_en)
            begin
                rd_ptr_r <= ~rd_ptr_r;
            end
        end
    end

    // slot write, storage left without reset
    always_ff @(posedge clk_i)
    begin
        if (wr_en)
        begin
            mem_r[wr_ptr_r] <= data_i;
        end
    end

    // head of the queue
    assign data_o = mem_r[rd_ptr_r];

endmodule

// ==== hdl/parallel_in_serial_out.sv ====
// zero-bubble serializer joining both buffers with word counter and output select
`timescale 1ns/1ns

module parallel_in_serial_out
(
    input  logic              clk_i,
    input  logic              rst_i,
    // bundle input, ready and valid
    input  logic              valid_i,
    input  piso_pkg::bundle_t data_i,
    output logic              ready_and_o,
    // word output, valid then yumi
    output logic              valid_o,
    output piso_pkg::word_t   data_o,
    input  logic              yumi_i
);

    // buffer handshakes
    logic last_ready;
    logic rest_ready;
    logic fifo_v_in;
    logic last_v;
    logic last_yumi;
    logic rest_yumi;

    // buffered words
    piso_pkg::word_t last_data;
    piso_pkg::rest_t rest_data;

    // index of the word on data_o
    piso_pkg::ctr_t ctr_r;

    // accept only when both buffers have room
    assign ready_and_o = last_ready & rest_ready;
    // one accepted bundle writes both buffers together
    assign fifo_v_in = valid_i & ready_and_o;

    // last word of each bundle
    // two entries let the next bundle land while the current one drains
    piso_two_fifo last
    (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .v_i     (fifo_v_in),
        .data_i  (data_i[piso_pkg::ELS*piso_pkg::WORD_W-1:piso_pkg::REST_W]),
        .ready_o (last_ready),
        .v_o     (last_v),
        .data_o  (last_data),
        .yumi_i  (last_yumi)
    );

    // words 0 to 2
    // valid is implied by last_v while the counter is below 3, so v_o stays open
    piso_one_fifo rest
    (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .v_i     (fifo_v_in),
        .data_i  (data_i[piso_pkg::REST_W-1:0]),
        .ready_o (rest_ready),
        .v_o     (),
        .data_o  (rest_data),
        .yumi_i  (rest_yumi)
    );

    // release the rest buffer at the second-last word so the next bundle can enter
    assign rest_yumi = yumi_i & (ctr_r == piso_pkg::ctr_t'(piso_pkg::ELS - 2));
    // last word out ends the bundle
    assign last_yumi = yumi_i & (ctr_r == piso_pkg::ctr_t'(piso_pkg::ELS - 1));

    // word counter
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            ctr_r <= '0;
        end
        else if (last_yumi)
        begin
            // wrap to word 0 of the next bundle
            ctr_r <= '0;
        end
        else if (yumi_i)
        begin
            ctr_r <= ctr_r + 1'b1;
        end
    end

    // output valid follows the last-word buffer
    assign valid_o = last_v;

    // output word select, low word first
    always_comb
    begin
        case (ctr_r)
            2'd0:
            begin
                data_o = rest_data[piso_pkg::WORD_W-1:0];
            end
            2'd1:
            begin
                data_o = rest_data[2*piso_pkg::WORD_W-1:piso_pkg::WORD_W];
            end
            2'd2:
            begin
                data_o = rest_data[3*piso_pkg::WORD_W-1:2*piso_pkg::WORD_W];
            end
            default:
            begin
                // counter at 3, word comes from the two-entry buffer
                data_o = last_data;
            end
        endcase
    end

endmodule

// ==== test/piso_tb_asserts.sv ====
// concurrent assertions on the serializer output protocol and word counter bound to the top
`timescale 1ns/1ns

module piso_tb_asserts
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            valid_o,
    input  piso_pkg::word_t data_o,
    input  logic            yumi_i,
    input  piso_pkg::ctr_t  ctr_r
);

    // output idle in the cycle following a reset edge
    property p_idle_after_reset;
        @(posedge clk_i) rst_i |=> !valid_o;
    endproperty

    // word held steady while the consumer stalls
    property p_data_hold;
        @(posedge clk_i) disable iff (rst_i)
            (valid_o && !yumi_i) |=> $stable(data_o);
    endproperty

    // counter rests at word 0 while no word is offered
    property p_ctr_idle;
        @(posedge clk_i) disable iff (rst_i)
            !valid_o |-> (ctr_r == '0);
    endproperty

    a_idle_after_reset: assert property (p_idle_after_reset)
        else $error("valid_o high in the cycle after reset");
    a_data_hold: assert property (p_data_hold)
        else $error("data_o changed while valid_o was high and yumi_i low");
    a_ctr_idle: assert property (p_ctr_idle)
        else $error("word counter not at zero while valid_o was low");

endmodule

bind parallel_in_serial_out piso_tb_asserts u_asserts
(
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_o (valid_o),
    .data_o  (data_o),
    .yumi_i  (yumi_i),
    .ctr_r   (ctr_r)
);

// ==== test/piso_tb.sv ====
// testbench for the serializer with trace stimulus, yumi back-pressure, checks and watchdog
`timescale 1ns/1ns

module piso_tb;

    localparam int max_lines       = 128;
    localparam int rst_cycles      = 8;
    localparam int cycles_per_line = 20;
    localparam logic [31:0] seed   = 32'd67915;
    localparam string trace_file   = "test/piso_trace.txt";

    logic              clk_i;
    logic              rst_i;
    logic              valid_i;
    piso_pkg::bundle_t data_i;
    logic              ready_and_o;
    logic              valid_o;
    piso_pkg::word_t   data_o;
    logic              yumi_i;

    // trace contents
    piso_pkg::bundle_t bundles [max_lines];
    int                idles [max_lines];
    int                phases [max_lines];
    piso_pkg::word_t   exp_words [max_lines*piso_pkg::ELS];
    int                n_lines;
    logic              trace_loaded;

    // words accepted by the DUT and not yet taken in arrival order
    piso_pkg::word_t pending [$];

    logic [31:0] rnd_state;
    int          idx;
    int          idle_left;
    int          accepted;
    int          words_taken;
    int          stall_cycles;

    initial
    begin
        clk_i = 1'b0;
    end

    always #5 clk_i = ~clk_i;

    parallel_in_serial_out dut
    (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .data_i      (data_i),
        .ready_and_o (ready_and_o),
        .valid_o     (valid_o),
        .data_o      (data_o),
        .yumi_i      (yumi_i)
    );

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic load_trace();
        int              fd;
        int              cnt;
        string           line;
        piso_pkg::bundle_t b;
        int              id;
        int              ph;
        piso_pkg::word_t e0;
        piso_pkg::word_t e1;
        piso_pkg::word_t e2;
        piso_pkg::word_t e3;
        fd = $fopen(trace_file, "r");
        if (fd == 0)
        begin
            fail_run("could not open the trace file");
        end
        n_lines = 0;
        while (!$feof(fd))
        begin
            line = "";
            cnt = $fgets(line, fd);
            // comment and blank lines match nothing
            cnt = $sscanf(line, "%h %d %d %h %h %h %h", b, id, ph, e0, e1, e2, e3);
            if (cnt == 7)
            begin
                if (n_lines == max_lines)
                begin
                    fail_run("the trace holds more bundles than the testbench can store");
                end
                bundles[n_lines] = b;
                idles[n_lines] = id;
                phases[n_lines] = ph;
                exp_words[n_lines*piso_pkg::ELS + 0] = e0;
                exp_words[n_lines*piso_pkg::ELS + 1] = e1;
                exp_words[n_lines*piso_pkg::ELS + 2] = e2;
                exp_words[n_lines*piso_pkg::ELS + 3] = e3;
                n_lines = n_lines + 1;
            end
        end
        $fclose(fd);
        if (n_lines == 0)
        begin
            fail_run("the trace holds no bundles");
        end
    endtask

    // checks first then drives consumer and producer on each falling edge
    task automatic step_cycle();
        piso_pkg::word_t expected;
        int              mode;
        int              k;
        mode = phases[(idx < n_lines) ? idx : n_lines - 1];
        // valid_o must be high exactly while accepted words wait to be taken
        assert (valid_o === (pending.size() != 0))
        else fail_run($sformatf("FAILED at %0t: valid_o expected %0b actual %0b",
                                $time, pending.size() != 0, valid_o));
        // ready_and_o high only while at most the last word of one bundle waits
        assert (ready_and_o === (pending.size() <= 1))
        else fail_run($sformatf("FAILED at %0t: ready_and_o expected %0b actual %0b",
                                $time, pending.size() <= 1, ready_and_o));
        yumi_i = 1'b0;
        if (valid_o)
        begin
            if (mode == 0)
            begin
                yumi_i = 1'b1;
            end
            else
            begin
                // yumi on one cycle in four gives long stalls
                rnd_state = xorshift32(rnd_state);
                yumi_i = (rnd_state[1:0] == 2'b00);
            end
        end
        if (yumi_i)
        begin
            expected = pending.pop_front();
            assert (data_o === expected)
            else fail_run($sformatf("FAILED at %0t: data_o expected %h actual %h",
                                    $time, expected, data_o));
            words_taken = words_taken + 1;
        end
        valid_i = 1'b0;
        if (idx < n_lines)
        begin
            if (idle_left > 0)
            begin
                idle_left = idle_left - 1;
            end
            else
            begin
                valid_i = 1'b1;
                data_i = bundles[idx];
                // ready_and_o ignores valid_i and is already final here
                if (ready_and_o)
                begin
                    for (k = 0; k < piso_pkg::ELS; k++)
                    begin
                        pending.push_back(exp_words[idx*piso_pkg::ELS + k]);
                    end
                    accepted = accepted + 1;
                    idx = idx + 1;
                    if (idx < n_lines)
                    begin
                        idle_left = idles[idx];
                    end
                end
                else
                begin
                    stall_cycles = stall_cycles + 1;
                end
            end
        end
    endtask

    initial
    begin
        rst_i = 1'b1;
        valid_i = 1'b0;
        data_i = '0;
        yumi_i = 1'b0;
        trace_loaded = 1'b0;
        rnd_state = seed;
        accepted = 0;
        words_taken = 0;
        stall_cycles = 0;
        idx = 0;
        load_trace();
        trace_loaded = 1'b1;
        idle_left = idles[0];
        repeat (rst_cycles) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        // first cycle out of reset
        assert (valid_o === 1'b0)
        else fail_run($sformatf("FAILED at %0t: valid_o expected 0 actual %b", $time, valid_o));
        assert (ready_and_o === 1'b1)
        else fail_run($sformatf("FAILED at %0t: ready_and_o expected 1 actual %b",
                                $time, ready_and_o));
        while (idx < n_lines || pending.size() != 0)
        begin
            step_cycle();
            @(negedge clk_i);
        end
        valid_i = 1'b0;
        yumi_i = 1'b0;
        // no word left in the DUT once every expected word is taken
        assert (valid_o === 1'b0)
        else fail_run($sformatf("FAILED at %0t: valid_o expected 0 actual %b", $time, valid_o));
        if (stall_cycles > 0)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
        begin
            fail_run($sformatf("producer never stalled over %0d bundles and %0d words",
                               accepted, words_taken));
        end
    end

    // watchdog sized from the trace length
    initial
    begin
        wait (trace_loaded === 1'b1);
        repeat (n_lines * cycles_per_line + rst_cycles) @(posedge clk_i);
        fail_run("the run did not finish before the watchdog limit");
    end

endmodule

// ==== flist.f ====
hdl/piso_pkg.sv
hdl/piso_one_fifo.sv
hdl/piso_two_fifo.sv
hdl/parallel_in_serial_out.sv
test/piso_tb_asserts.sv
test/piso_tb.sv

// ==== Makefile ====
# Verilator lint, simulation and clean targets for the serializer

VERILATOR   ?= verilator
TOP         ?= piso_tb
RTL_TOP     ?= parallel_in_serial_out
FLIST       ?= flist.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0
LINT_FLAGS  ?= --lint-only

SOURCES := $(shell cat $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint lint_rtl sim build clean

all: sim

# lint the whole bench, testbench included
lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# lint the design on its own
lint_rtl:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		hdl/piso_pkg.sv hdl/piso_one_fifo.sv hdl/piso_two_fifo.sv hdl/parallel_in_serial_out.sv

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the binary is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/piso_trace.txt ====
# columns: bundle (hex, word 0 low) idle_cycles phase (0 yumi high, 1 random)
# then the four expected words in hex, word 0 first
03020100 2 0 00 01 02 03
07060504 0 0 04 05 06 07
0b0a0908 0 0 08 09 0a 0b
0f0e0d0c 0 0 0c 0d 0e 0f
13121110 3 0 10 11 12 13
17161514 0 0 14 15 16 17
1b1a1918 1 0 18 19 1a 1b
1f1e1d1c 0 0 1c 1d 1e 1f
23222120 0 0 20 21 22 23
27262524 0 0 24 25 26 27
2b2a2928 5 0 28 29 2a 2b
2f2e2d2c 0 0 2c 2d 2e 2f
33323130 0 0 30 31 32 33
37363534 2 0 34 35 36 37
3b3a3938 0 0 38 39 3a 3b
3f3e3d3c 0 0 3c 3d 3e 3f
43424140 0 1 40 41 42 43
47464544 0 1 44 45 46 47
4b4a4948 0 1 48 49 4a 4b
4f4e4d4c 0 1 4c 4d 4e 4f
53525150 0 1 50 51 52 53
57565554 0 1 54 55 56 57
5b5a5958 0 1 58 59 5a 5b
5f5e5d5c 0 1 5c 5d 5e 5f
63626160 1 1 60 61 62 63
67666564 0 1 64 65 66 67
6b6a6968 0 1 68 69 6a 6b
6f6e6d6c 0 1 6c 6d 6e 6f
73727170 0 1 70 71 72 73
77767574 0 1 74 75 76 77
7b7a7978 0 1 78 79 7a 7b
7f7e7d7c 0 1 7c 7d 7e 7f
83828180 2 1 80 81 82 83
87868584 0 1 84 85 86 87
8b8a8988 0 1 88 89 8a 8b
8f8e8d8c 0 1 8c 8d 8e 8f
93929190 0 1 90 91 92 93
97969594 0 1 94 95 96 97
9b9a9998 0 1 98 99 9a 9b
9f9e9d9c 0 1 9c 9d 9e 9f
a3a2a1a0 0 0 a0 a1 a2 a3
a7a6a5a4 0 0 a4 a5 a6 a7
abaaa9a8 0 0 a8 a9 aa ab
afaeadac 0 0 ac ad ae af
b3b2b1b0 0 0 b0 b1 b2 b3
b7b6b5b4 0 0 b4 b5 b6 b7
bbbab9b8 0 0 b8 b9 ba bb
bfbebdbc 0 0 bc bd be bf
c3c2c1c0 0 0 c0 c1 c2 c3
c7c6c5c4 0 0 c4 c5 c6 c7
cbcac9c8 0 0 c8 c9 ca cb
cfcecdcc 0 0 cc cd ce cf
d3d2d1d0 1 1 d0 d1 d2 d3
d7d6d5d4 0 1 d4 d5 d6 d7
dbdad9d8 3 1 d8 d9 da db
dfdedddc 0 1 dc dd de df
e3e2e1e0 0 1 e0 e1 e2 e3
e7e6e5e4 2 1 e4 e5 e6 e7
ebeae9e8 0 1 e8 e9 ea eb
efeeedec 0 1 ec ed ee ef
f3f2f1f0 4 1 f0 f1 f2 f3
f7f6f5f4 0 1 f4 f5 f6 f7
fbfaf9f8 1 1 f8 f9 fa fb
fffefdfc 0 1 fc fd fe ff
